/* Bender.yml */
package:
  name: mem_stage

sources:
  - hdl/mem_stage_pkg.sv
  - hdl/mem_access_ctrl.sv
  - hdl/store_align.sv
  - hdl/data_ram.sv
  - hdl/load_extend.sv
  - hdl/mem_stage_top.sv
  - target: test
    files:
      - tb/tb_mem_stage.sv

/* compile.f */
hdl/mem_stage_pkg.sv
hdl/mem_access_ctrl.sv
hdl/store_align.sv
hdl/data_ram.sv
hdl/load_extend.sv
hdl/mem_stage_top.sv
tb/tb_mem_stage.sv

/* hdl/data_ram.sv */
module data_ram #(
    parameter int DEPTH = 16,
    localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
    input  logic                    i_clk,
    input  logic                    i_we,
    input  mem_stage_pkg::byte_en_t i_be,
    input  logic                    i_re,
    input  logic [IDX_W-1:0]        i_word_idx,
    input  mem_stage_pkg::word_t    i_wdata,
    input  logic                    i_dbg_re,
    input  logic [IDX_W-1:0]        i_dbg_idx,
    output mem_stage_pkg::word_t    o_rdata,
    output mem_stage_pkg::word_t    o_dbg_rdata
);

    localparam int LANES = mem_stage_pkg::DATA_W / 8;

    mem_stage_pkg::word_t mem [DEPTH];

    // Word i starts out as 2*i
    initial
    begin
        for (int i = 0; i < DEPTH; i++)
        begin
            mem[i] = mem_stage_pkg::word_t'(2 * i);
        end
    end

    ////////////////////////////////////////
    // Byte-lane write
    ////////////////////////////////////////

    always_ff @(posedge i_clk)
    begin
        if (i_we)
        begin
            for (int b = 0; b < LANES; b++)
            begin
                if (i_be[b])
                begin
                    mem[i_word_idx][8*b +: 8] <= i_wdata[8*b +: 8];
                end
            end
        end
    end

    // Both ports return the word as it was before this edge's write
    always_ff @(posedge i_clk)
    begin
        if (i_re)
        begin
            o_rdata <= mem[i_word_idx];
        end
        if (i_dbg_re)
        begin
            o_dbg_rdata <= mem[i_dbg_idx];
        end
    end

    a_idx_range: assert property (@(posedge i_clk) i_we |-> (i_word_idx < DEPTH));

endmodule

/* hdl/load_extend.sv */
module load_extend (
    input  mem_stage_pkg::word_t i_rdata,
    input  mem_stage_pkg::size_t i_size,
    input  logic [1:0]           i_off,
    input  logic                 i_signed,
    output mem_stage_pkg::word_t o_data
);

    localparam int DW = mem_stage_pkg::DATA_W;

    mem_stage_pkg::word_t shifted;
    logic                 byte_fill;
    logic                 half_fill;

    ////////////////////////////////////////
    // Lane select
    ////////////////////////////////////////

    // Addressed lane moved down to bit 0
    assign shifted = i_rdata >> {i_off, 3'b000};

    // Sign bit, or zero for unsigned loads
    assign byte_fill = i_signed && shifted[7];
    assign half_fill = i_signed && shifted[15];

    ////////////////////////////////////////
    // Extension
    ////////////////////////////////////////

    always_comb
    begin
        case (i_size)
            mem_stage_pkg::SIZE_B:
            begin
                o_data = {{(DW-8){byte_fill}}, shifted[7:0]};
            end
            mem_stage_pkg::SIZE_H:
            begin
                o_data = {{(DW-16){half_fill}}, shifted[15:0]};
            end
            mem_stage_pkg::SIZE_W:
            begin
                // Whole word, offset is zero
                o_data = i_rdata;
            end
            default:
            begin
                o_data = i_rdata;
            end
        endcase
    end

endmodule

/* hdl/mem_access_ctrl.sv */
module mem_access_ctrl #(
    parameter int DEPTH = 16,
    localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
    input  logic                  i_clk,
    input  logic                  i_arst_n,
    input  logic                  i_req,
    input  mem_stage_pkg::mem_op_t i_op,
    input  mem_stage_pkg::word_t  i_addr,
    input  logic                  i_dbg_start,
    output logic                  o_we,
    output logic                  o_re,
    output logic [IDX_W-1:0]      o_word_idx,
    output mem_stage_pkg::size_t  o_size,
    output logic [1:0]            o_byte_off,
    output mem_stage_pkg::size_t  o_ld_size,
    output logic [1:0]            o_ld_off,
    output logic                  o_ld_signed,
    output logic                  o_load_valid,
    output logic                  o_misaligned,
    output logic                  o_dbg_re,
    output logic [IDX_W-1:0]      o_dbg_idx,
    output logic                  o_dbg_valid,
    output logic [IDX_W-1:0]      o_dbg_addr,
    output logic                  o_dbg_done
);

    typedef enum logic {
        DUMP_IDLE,
        DUMP_RUN
    } dump_state_t;

    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(DEPTH - 1);

    logic                 is_load;
    logic                 is_signed;
    logic                 aligned;
    mem_stage_pkg::word_t word_num;
    mem_stage_pkg::word_t word_mod;
    dump_state_t          state_q;
    logic [IDX_W-1:0]     dbg_idx_q;

    ////////////////////////////////////////
    // Request decode
    ////////////////////////////////////////

    always_comb
    begin
        case (i_op)
            mem_stage_pkg::OP_LB, mem_stage_pkg::OP_LBU, mem_stage_pkg::OP_SB:
                o_size = mem_stage_pkg::SIZE_B;
            mem_stage_pkg::OP_LH, mem_stage_pkg::OP_LHU, mem_stage_pkg::OP_SH:
                o_size = mem_stage_pkg::SIZE_H;
            default:
                o_size = mem_stage_pkg::SIZE_W;
        endcase
    end

    // Everything but the three store codes is a load
    assign is_load   = (i_op != mem_stage_pkg::OP_SB) && (i_op != mem_stage_pkg::OP_SH) &&
                       (i_op != mem_stage_pkg::OP_SW);
    assign is_signed = (i_op == mem_stage_pkg::OP_LB) || (i_op == mem_stage_pkg::OP_LH);

    // Halfwords on even addresses, words on multiples of four
    assign aligned = (o_size == mem_stage_pkg::SIZE_B) ||
                     (o_size == mem_stage_pkg::SIZE_H && !i_addr[0]) ||
                     (o_size == mem_stage_pkg::SIZE_W && i_addr[1:0] == 2'b00);

    assign o_we = i_req && !is_load && aligned;
    assign o_re = i_req && is_load && aligned;

    // Word index wraps modulo DEPTH
    assign word_num   = i_addr >> 2;
    assign word_mod   = word_num % mem_stage_pkg::word_t'(DEPTH);
    assign o_word_idx = word_mod[IDX_W-1:0];
    assign o_byte_off = i_addr[1:0];

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            o_load_valid <= 1'b0;
            o_misaligned <= 1'b0;
        end
        else
        begin
            o_load_valid <= o_re;
            o_misaligned <= i_req && !aligned;
        end
    end

    // Load attributes line up with the read data
    always_ff @(posedge i_clk)
    begin
        if (o_re)
        begin
            o_ld_size   <= o_size;
            o_ld_off    <= i_addr[1:0];
            o_ld_signed <= is_signed;
        end
    end

    ////////////////////////////////////////
    // Debug dump sequencer
    ////////////////////////////////////////

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            state_q   <= DUMP_IDLE;
            dbg_idx_q <= '0;
        end
        else
        begin
            case (state_q)
                DUMP_IDLE:
                begin
                    dbg_idx_q <= '0;
                    if (i_dbg_start)
                    begin
                        state_q <= DUMP_RUN;
                    end
                end
                DUMP_RUN:
                begin
                    dbg_idx_q <= dbg_idx_q + 1'b1;
                    if (dbg_idx_q == LAST_IDX)
                    begin
                        state_q <= DUMP_IDLE;
                    end
                end
                default: state_q <= DUMP_IDLE;
            endcase
        end
    end

    assign o_dbg_re  = (state_q == DUMP_RUN);
    assign o_dbg_idx = dbg_idx_q;

    // One cycle behind the debug read, matching the RAM latency
    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            o_dbg_valid <= 1'b0;
            o_dbg_done  <= 1'b0;
        end
        else
        begin
            o_dbg_valid <= o_dbg_re;
            o_dbg_done  <= o_dbg_re && (dbg_idx_q == LAST_IDX);
        end
    end

    always_ff @(posedge i_clk)
    begin
        o_dbg_addr <= dbg_idx_q;
    end

    // Indices step by one through a dump
    a_dbg_step: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_dbg_valid && !o_dbg_done |=> o_dbg_valid && (o_dbg_addr == $past(o_dbg_addr) + 1'b1));

    // Done comes with the last word and ends the stream
    a_done_last: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_dbg_done |-> o_dbg_valid ##1 !o_dbg_valid);

endmodule

/* hdl/mem_stage_pkg.sv */
package mem_stage_pkg;

    ////////////////////////////////////////
    // Widths
    ////////////////////////////////////////

    localparam int DATA_W = 32;

    // Data words and byte addresses
    typedef logic [DATA_W-1:0]   word_t;

    // Lane 0 is the least significant byte
    typedef logic [DATA_W/8-1:0] byte_en_t;

    typedef logic [2:0]          mem_op_t;
    typedef logic [1:0]          size_t;

    ////////////////////////////////////////
    // Operation codes
    ////////////////////////////////////////

    // Loads
    localparam mem_op_t OP_LB  = 3'd0;
    localparam mem_op_t OP_LH  = 3'd1;
    localparam mem_op_t OP_LW  = 3'd2;
    localparam mem_op_t OP_LBU = 3'd3;
    localparam mem_op_t OP_LHU = 3'd4;

    // Stores
    localparam mem_op_t OP_SB  = 3'd5;
    localparam mem_op_t OP_SH  = 3'd6;
    localparam mem_op_t OP_SW  = 3'd7;

    // Access sizes
    localparam size_t SIZE_B = 2'd0;
    localparam size_t SIZE_H = 2'd1;
    localparam size_t SIZE_W = 2'd2;

endpackage

/* hdl/mem_stage_top.sv */
module mem_stage_top #(
    parameter int DEPTH = 16,
    localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
    input  logic                   i_clk,
    input  logic                   i_arst_n,
    input  logic                   i_req,
    input  mem_stage_pkg::mem_op_t i_op,
    input  mem_stage_pkg::word_t   i_addr,
    input  mem_stage_pkg::word_t   i_wdata,
    input  logic                   i_dbg_start,
    output logic                   o_load_valid,
    output mem_stage_pkg::word_t   o_load_data,
    output logic                   o_misaligned,
    output logic                   o_dbg_valid,
    output logic [IDX_W-1:0]       o_dbg_addr,
    output mem_stage_pkg::word_t   o_dbg_data,
    output logic                   o_dbg_done
);

    // Access path
    logic                    we;
    logic                    re;
    logic [IDX_W-1:0]        word_idx;
    mem_stage_pkg::size_t    size;
    logic [1:0]              byte_off;
    mem_stage_pkg::byte_en_t be;
    mem_stage_pkg::word_t    wdata_aligned;
    mem_stage_pkg::word_t    rdata;

    // Load attributes, one cycle late
    mem_stage_pkg::size_t    ld_size;
    logic [1:0]              ld_off;
    logic                    ld_signed;

    // Debug port
    logic                    dbg_re;
    logic [IDX_W-1:0]        dbg_idx;

    ////////////////////////////////////////
    // Control
    ////////////////////////////////////////

    mem_access_ctrl #(
        .DEPTH (DEPTH)
    ) u_ctrl (
        .i_clk        (i_clk),
        .i_arst_n     (i_arst_n),
        .i_req        (i_req),
        .i_op         (i_op),
        .i_addr       (i_addr),
        .i_dbg_start  (i_dbg_start),
        .o_we         (we),
        .o_re         (re),
        .o_word_idx   (word_idx),
        .o_size       (size),
        .o_byte_off   (byte_off),
        .o_ld_size    (ld_size),
        .o_ld_off     (ld_off),
        .o_ld_signed  (ld_signed),
        .o_load_valid (o_load_valid),
        .o_misaligned (o_misaligned),
        .o_dbg_re     (dbg_re),
        .o_dbg_idx    (dbg_idx),
        .o_dbg_valid  (o_dbg_valid),
        .o_dbg_addr   (o_dbg_addr),
        .o_dbg_done   (o_dbg_done)
    );

    ////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////

    store_align u_store_align (
        .i_size          (size),
        .i_byte_off      (byte_off),
        .i_wdata         (i_wdata),
        .o_be            (be),
        .o_wdata_aligned (wdata_aligned)
    );

    data_ram #(
        .DEPTH (DEPTH)
    ) u_ram (
        .i_clk       (i_clk),
        .i_we        (we),
        .i_be        (be),
        .i_re        (re),
        .i_word_idx  (word_idx),
        .i_wdata     (wdata_aligned),
        .i_dbg_re    (dbg_re),
        .i_dbg_idx   (dbg_idx),
        .o_rdata     (rdata),
        .o_dbg_rdata (o_dbg_data)
    );

    load_extend u_load_extend (
        .i_rdata  (rdata),
        .i_size   (ld_size),
        .i_off    (ld_off),
        .i_signed (ld_signed),
        .o_data   (o_load_data)
    );

endmodule

/* hdl/store_align.sv */
module store_align (
    input  mem_stage_pkg::size_t    i_size,
    input  logic [1:0]              i_byte_off,
    input  mem_stage_pkg::word_t    i_wdata,
    output mem_stage_pkg::byte_en_t o_be,
    output mem_stage_pkg::word_t    o_wdata_aligned
);

    localparam int LANES = mem_stage_pkg::DATA_W / 8;

    logic [1:0] half_off;

    // Halfword lanes start on an even byte
    assign half_off = {i_byte_off[1], 1'b0};

    always_comb
    begin
        case (i_size)
            mem_stage_pkg::SIZE_B:
            begin
                // Byte copied into every lane
                o_wdata_aligned = {LANES{i_wdata[7:0]}};
                o_be            = mem_stage_pkg::byte_en_t'(1) << i_byte_off;
            end
            mem_stage_pkg::SIZE_H:
            begin
                o_wdata_aligned = {(LANES/2){i_wdata[15:0]}};
                o_be            = mem_stage_pkg::byte_en_t'(3) << half_off;
            end
            mem_stage_pkg::SIZE_W:
            begin
                o_wdata_aligned = i_wdata;
                o_be            = '1;
            end
            default:
            begin
                // Unknown size writes nothing
                o_wdata_aligned = i_wdata;
                o_be            = '0;
            end
        endcase
    end

endmodule

/* tb/tb_mem_stage.sv */
module tb_mem_stage;

    localparam int DEPTH      = 16;
    localparam int IDX_W      = $clog2(DEPTH);
    localparam int RING       = 64;
    localparam int WAIT_LIMIT = 200;
    localparam int N_STORES   = 48;
    localparam int N_LOADS    = 64;
    localparam int N_MISALIGN = 12;
    localparam logic [31:0] SEED = 32'h02baa220;

    logic                   i_clk;
    logic                   i_arst_n;
    logic                   i_req;
    mem_stage_pkg::mem_op_t i_op;
    mem_stage_pkg::word_t   i_addr;
    mem_stage_pkg::word_t   i_wdata;
    logic                   i_dbg_start;
    logic                   o_load_valid;
    mem_stage_pkg::word_t   o_load_data;
    logic                   o_misaligned;
    logic                   o_dbg_valid;
    logic [IDX_W-1:0]       o_dbg_addr;
    mem_stage_pkg::word_t   o_dbg_data;
    logic                   o_dbg_done;

    // Reference memory and random state
    mem_stage_pkg::word_t model [DEPTH];
    logic [31:0]          rand_state;

    int cyc = 0;
    int last_exp_cyc = 0;
    int loads_issued = 0;
    int loads_checked = 0;
    int words_expected = 0;
    int words_checked = 0;

    // Expected outputs, one slot per cycle in a ring
    bit                   exp_load_vld [RING];
    mem_stage_pkg::word_t exp_load_val [RING];
    bit                   exp_mis      [RING];
    bit                   exp_dbg_vld  [RING];
    logic [IDX_W-1:0]     exp_dbg_idx  [RING];
    mem_stage_pkg::word_t exp_dbg_val  [RING];

    mem_stage_top #(
        .DEPTH (DEPTH)
    ) UUT (
        .i_clk        (i_clk),
        .i_arst_n     (i_arst_n),
        .i_req        (i_req),
        .i_op         (i_op),
        .i_addr       (i_addr),
        .i_wdata      (i_wdata),
        .i_dbg_start  (i_dbg_start),
        .o_load_valid (o_load_valid),
        .o_load_data  (o_load_data),
        .o_misaligned (o_misaligned),
        .o_dbg_valid  (o_dbg_valid),
        .o_dbg_addr   (o_dbg_addr),
        .o_dbg_data   (o_dbg_data),
        .o_dbg_done   (o_dbg_done)
    );

    initial
    begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
    end

    always @(posedge i_clk)
    begin
        cyc <= cyc + 1;
    end

    ////////////////////////////////////////
    // Error reporting
    ////////////////////////////////////////

    task automatic report_error(input string text);
        $display("%s", text);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input mem_stage_pkg::word_t expected,
                                   input mem_stage_pkg::word_t actual);
        $display("Mismatch at time %0t: %s expected %h, got %h", $time, name, expected, actual);
        $display("Finished with errors");
        $fatal(1);
    endtask

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    function automatic logic [31:0] rand_word();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    function automatic bit is_load_op(input mem_stage_pkg::mem_op_t op);
        return op == mem_stage_pkg::OP_LB || op == mem_stage_pkg::OP_LH ||
               op == mem_stage_pkg::OP_LW || op == mem_stage_pkg::OP_LBU ||
               op == mem_stage_pkg::OP_LHU;
    endfunction

    function automatic bit access_aligned(input mem_stage_pkg::mem_op_t op,
                                          input mem_stage_pkg::word_t addr);
        case (op)
            mem_stage_pkg::OP_LH, mem_stage_pkg::OP_LHU, mem_stage_pkg::OP_SH:
                return addr[0] == 1'b0;
            mem_stage_pkg::OP_LW, mem_stage_pkg::OP_SW:
                return addr[1:0] == 2'b00;
            default:
                return 1'b1;
        endcase
    endfunction

    function automatic int word_index(input mem_stage_pkg::word_t addr);
        return int'((addr >> 2) % DEPTH);
    endfunction

    // Expected load result from the reference memory
    function automatic mem_stage_pkg::word_t expected_load(input mem_stage_pkg::mem_op_t op,
                                                           input mem_stage_pkg::word_t addr);
        mem_stage_pkg::word_t w;
        mem_stage_pkg::word_t lane;
        w    = model[word_index(addr)];
        lane = w >> (8 * addr[1:0]);
        case (op)
            mem_stage_pkg::OP_LB:  return {{24{lane[7]}}, lane[7:0]};
            mem_stage_pkg::OP_LBU: return {24'h0, lane[7:0]};
            mem_stage_pkg::OP_LH:  return {{16{lane[15]}}, lane[15:0]};
            mem_stage_pkg::OP_LHU: return {16'h0, lane[15:0]};
            default:               return w;
        endcase
    endfunction

    task automatic apply_store(input mem_stage_pkg::mem_op_t op, input mem_stage_pkg::word_t addr,
                               input mem_stage_pkg::word_t wdata);
        int idx;
        int off;
        idx = word_index(addr);
        off = int'(addr[1:0]);
        case (op)
            mem_stage_pkg::OP_SB: model[idx][8*off +: 8]  = wdata[7:0];
            mem_stage_pkg::OP_SH: model[idx][8*off +: 16] = wdata[15:0];
            default:              model[idx] = wdata;
        endcase
    endtask

    function automatic void note_expectation(input int c);
        if (c > last_exp_cyc)
            last_exp_cyc = c;
    endfunction

    ////////////////////////////////////////
    // Compare process
    ////////////////////////////////////////

    task automatic check_cycle(input int slot);
        bit exp_done;
        exp_done = exp_dbg_vld[slot] && (exp_dbg_idx[slot] == IDX_W'(DEPTH - 1));
        assert (o_load_valid === exp_load_vld[slot])
        else report_mismatch("o_load_valid", 32'(exp_load_vld[slot]), 32'(o_load_valid));
        if (exp_load_vld[slot])
        begin
            assert (o_load_data === exp_load_val[slot])
            else report_mismatch("o_load_data", exp_load_val[slot], o_load_data);
            loads_checked++;
        end
        assert (o_misaligned === exp_mis[slot])
        else report_mismatch("o_misaligned", 32'(exp_mis[slot]), 32'(o_misaligned));
        assert (o_dbg_valid === exp_dbg_vld[slot])
        else report_mismatch("o_dbg_valid", 32'(exp_dbg_vld[slot]), 32'(o_dbg_valid));
        assert (o_dbg_done === exp_done)
        else report_mismatch("o_dbg_done", 32'(exp_done), 32'(o_dbg_done));
        if (exp_dbg_vld[slot])
        begin
            assert (o_dbg_addr === exp_dbg_idx[slot])
            else report_mismatch("o_dbg_addr", 32'(exp_dbg_idx[slot]), 32'(o_dbg_addr));
            assert (o_dbg_data === exp_dbg_val[slot])
            else report_mismatch("o_dbg_data", exp_dbg_val[slot], o_dbg_data);
            words_checked++;
        end
        exp_load_vld[slot] = 1'b0;
        exp_mis[slot]      = 1'b0;
        exp_dbg_vld[slot]  = 1'b0;
    endtask

    // Outputs are all registered, so the falling edge sees them settled
    always @(negedge i_clk)
    begin
        if (i_arst_n === 1'b1)
        begin
            check_cycle(cyc % RING);
        end
    end

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    task automatic drive_access(input mem_stage_pkg::mem_op_t op, input mem_stage_pkg::word_t addr,
                                input mem_stage_pkg::word_t wdata);
        int slot;
        @(negedge i_clk);
        slot        = (cyc + 1) % RING;
        i_req       = 1'b1;
        i_op        = op;
        i_addr      = addr;
        i_wdata     = wdata;
        i_dbg_start = 1'b0;
        if (!access_aligned(op, addr))
        begin
            exp_mis[slot] = 1'b1;
        end
        else if (is_load_op(op))
        begin
            exp_load_vld[slot] = 1'b1;
            exp_load_val[slot] = expected_load(op, addr);
            loads_issued++;
        end
        else
        begin
            apply_store(op, addr, wdata);
        end
        note_expectation(cyc + 1);
    endtask

    task automatic drive_idle();
        @(negedge i_clk);
        i_req       = 1'b0;
        i_dbg_start = 1'b0;
    endtask

    // A second strobe at cycle second_start into the dump, none if negative
    task automatic run_dump(input int second_start);
        int  base;
        int  slot;
        int  n;
        bit  seen;
        @(negedge i_clk);
        i_req       = 1'b0;
        i_dbg_start = 1'b1;
        base        = cyc;
        for (int k = 0; k < DEPTH; k++)
        begin
            slot              = (base + 2 + k) % RING;
            exp_dbg_vld[slot] = 1'b1;
            exp_dbg_idx[slot] = IDX_W'(k);
            exp_dbg_val[slot] = model[k];
        end
        words_expected += DEPTH;
        note_expectation(base + 1 + DEPTH);
        n    = 0;
        seen = 1'b0;
        while (!seen && n < WAIT_LIMIT)
        begin
            @(negedge i_clk);
            n++;
            i_dbg_start = (n == second_start);
            seen        = (o_dbg_done === 1'b1);
        end
        if (!seen)
            report_error("Timed out waiting for the end of a debug dump");
    endtask

    task automatic read_all_words();
        for (int i = 0; i < DEPTH; i++)
        begin
            drive_access(mem_stage_pkg::OP_LW, mem_stage_pkg::word_t'(4 * i), '0);
        end
        drive_idle();
    endtask

    mem_stage_pkg::mem_op_t store_ops [3];
    mem_stage_pkg::mem_op_t load_ops  [5];
    mem_stage_pkg::mem_op_t bad_ops   [4];

    initial
    begin
        mem_stage_pkg::mem_op_t op;
        mem_stage_pkg::word_t   addr;
        int                     n;

        i_arst_n    = 1'b0;
        i_req       = 1'b0;
        i_op        = mem_stage_pkg::OP_LW;
        i_addr      = '0;
        i_wdata     = '0;
        i_dbg_start = 1'b0;
        rand_state  = SEED;
        store_ops   = '{mem_stage_pkg::OP_SB, mem_stage_pkg::OP_SH, mem_stage_pkg::OP_SW};
        load_ops    = '{mem_stage_pkg::OP_LB, mem_stage_pkg::OP_LH, mem_stage_pkg::OP_LW,
                        mem_stage_pkg::OP_LBU, mem_stage_pkg::OP_LHU};
        bad_ops     = '{mem_stage_pkg::OP_LH, mem_stage_pkg::OP_SH,
                        mem_stage_pkg::OP_LW, mem_stage_pkg::OP_SW};
        for (int i = 0; i < DEPTH; i++)
        begin
            model[i] = mem_stage_pkg::word_t'(2 * i);
        end

        repeat (5) @(posedge i_clk);
        @(negedge i_clk);
        i_arst_n = 1'b1;
        assert (o_load_valid === 1'b0 && o_misaligned === 1'b0 &&
                o_dbg_valid === 1'b0 && o_dbg_done === 1'b0)
        else report_error("A strobe output is not low after reset");

        // Initial contents
        read_all_words();

        // Random aligned stores, then back-to-back loads
        for (int i = 0; i < N_STORES; i++)
        begin
            op   = store_ops[rand_word() % 3];
            addr = rand_word();
            if (op == mem_stage_pkg::OP_SH)
                addr[0] = 1'b0;
            else if (op == mem_stage_pkg::OP_SW)
                addr[1:0] = 2'b00;
            drive_access(op, addr, rand_word());
        end
        for (int i = 0; i < N_LOADS; i++)
        begin
            op   = load_ops[rand_word() % 5];
            addr = rand_word();
            if (op == mem_stage_pkg::OP_LH || op == mem_stage_pkg::OP_LHU)
                addr[0] = 1'b0;
            else if (op == mem_stage_pkg::OP_LW)
                addr[1:0] = 2'b00;
            drive_access(op, addr, '0);
        end
        drive_idle();

        // Misaligned accesses leave memory untouched
        for (int i = 0; i < N_MISALIGN; i++)
        begin
            op   = bad_ops[i % 4];
            addr = rand_word();
            if (op == mem_stage_pkg::OP_LH || op == mem_stage_pkg::OP_SH)
                addr[0] = 1'b1;
            else
                addr[1:0] = 2'(1 + rand_word() % 3);
            drive_access(op, addr, rand_word());
        end
        drive_idle();
        read_all_words();

        // Dump while idle, then a dump with a second start strobe
        run_dump(-1);
        drive_idle();
        run_dump(4);
        drive_idle();

        // Idle tail long enough to catch words beyond the expected dumps
        n = 0;
        while (cyc <= last_exp_cyc + DEPTH && n < WAIT_LIMIT)
        begin
            @(negedge i_clk);
            n++;
        end
        if (cyc <= last_exp_cyc + DEPTH)
            report_error("Timed out waiting for the last expected result");

        if (loads_checked == loads_issued && words_checked == words_expected)
        begin
            $display("Finished with no errors");
            $finish;
        end
        else
        begin
            $display("Checked %0d of %0d loads and %0d of %0d dump words",
                     loads_checked, loads_issued, words_checked, words_expected);
            $display("Finished with errors");
            $fatal(1);
        end
    end

endmodule
